/* Makefile */
TOP = tb_cache_aq_sys
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f cache_aq_sys.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* access_queue.sv */
`include "aq_cfg.svh"

module access_queue #(
    parameter int ENTRY_W = `AQ_SHORT_W,
    parameter int DEPTH   = `AQ_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               write_i,
    input  logic               pop_i,
    input  logic [ENTRY_W-1:0] entry_i,
    output logic [ENTRY_W-1:0] entry_o,
    output logic               empty_o,
    output logic               full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // a pop on a full queue frees the slot for a push in the same cycle
    assign do_pop  = pop_i && !empty_o;
    assign do_push = write_i && (!full_o || do_pop);

    // show-ahead head
    assign entry_o = empty_o ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* aq_arbiter.sv */
module aq_arbiter (
    input  logic              bus_full_i,
    input  logic              wb_empty_i,
    input  logic              sw_empty_i,
    input  logic              rd_empty_i,
    input  logic              read_i,
    output aq_pkg::aq_src_e   src_o,
    output logic              r_o,
    output logic              sw_o,
    output logic              w_o,
    output logic              from_bus_o,
    output logic              pop_rd_o,
    output logic              pop_sw_o,
    output logic              pop_wb_o,
    output logic              pop_bus_o,
    output logic              aq_empty_o
);

    import aq_pkg::*;

    // bus wins, then write-back, then store-write, then read
    assign from_bus_o = bus_full_i;
    assign w_o        = !bus_full_i && !wb_empty_i;
    assign sw_o       = !bus_full_i && wb_empty_i && !sw_empty_i;
    assign r_o        = !bus_full_i && wb_empty_i && sw_empty_i && !rd_empty_i;

    assign aq_empty_o = !bus_full_i && wb_empty_i && sw_empty_i && rd_empty_i;

    always_comb begin
        if (bus_full_i) begin
            src_o = SRC_BUS;
        end else if (!wb_empty_i) begin
            src_o = SRC_WB;
        end else if (!sw_empty_i) begin
            src_o = SRC_SW;
        end else begin
            src_o = SRC_RD;
        end
    end

    // only the presented source sees the pop
    assign pop_bus_o = read_i && from_bus_o;
    assign pop_wb_o  = read_i && w_o;
    assign pop_sw_o  = read_i && sw_o;
    assign pop_rd_o  = read_i && r_o;

endmodule

/* aq_cfg.svh */
`ifndef AQ_CFG_SVH
`define AQ_CFG_SVH

// per-bank field widths
`define AQ_ADDR_W   15
`define AQ_DATA_W   32
`define AQ_MASK_W   4
`define AQ_SIZE_W   2
`define AQ_PTCID_W  7

// entries per core queue
`define AQ_DEPTH    4

// short entry holds valids, addresses, sizes, ptcid and pcd
`define AQ_SHORT_W  (2 + 2*`AQ_ADDR_W + 2*`AQ_SIZE_W + `AQ_PTCID_W + 1)

// long entry adds data and masks on top of the short entry
`define AQ_LONG_W   (2*`AQ_DATA_W + 2*`AQ_MASK_W + `AQ_SHORT_W)

// fill entry holds valids, addresses, data and pcd
`define AQ_FILL_W   (2 + 2*`AQ_ADDR_W + 2*`AQ_DATA_W + 1)

`endif

/* aq_out_mux.sv */
`include "aq_cfg.svh"

module aq_out_mux (
    input  aq_pkg::aq_src_e          src_i,
    input  logic                     any_i,
    input  logic [`AQ_SHORT_W-1:0]   rd_entry_i,
    input  logic [`AQ_SHORT_W-1:0]   sw_entry_i,
    input  logic [`AQ_LONG_W-1:0]    wb_entry_i,
    input  logic [`AQ_FILL_W-1:0]    bus_entry_i,
    output logic                     valid_e_o,
    output logic                     valid_o_o,
    output logic [`AQ_ADDR_W-1:0]    addr_e_o,
    output logic [`AQ_ADDR_W-1:0]    addr_o_o,
    output logic [`AQ_DATA_W-1:0]    data_e_o,
    output logic [`AQ_DATA_W-1:0]    data_o_o,
    output logic [`AQ_SIZE_W-1:0]    size_e_o,
    output logic [`AQ_SIZE_W-1:0]    size_o_o,
    output logic [`AQ_MASK_W-1:0]    mask_e_o,
    output logic [`AQ_MASK_W-1:0]    mask_o_o,
    output logic [`AQ_PTCID_W-1:0]   ptcid_o,
    output logic                     pcd_o
);

    import aq_pkg::*;

    logic [`AQ_SHORT_W-1:0] core_sel;

    logic                   c_valid_e;
    logic                   c_valid_o;
    logic [`AQ_ADDR_W-1:0]  c_addr_e;
    logic [`AQ_ADDR_W-1:0]  c_addr_o;
    logic [`AQ_SIZE_W-1:0]  c_size_e;
    logic [`AQ_SIZE_W-1:0]  c_size_o;
    logic [`AQ_PTCID_W-1:0] c_ptcid;
    logic                   c_pcd;

    logic [`AQ_DATA_W-1:0]  w_data_e;
    logic [`AQ_DATA_W-1:0]  w_data_o;
    logic [`AQ_MASK_W-1:0]  w_mask_e;
    logic [`AQ_MASK_W-1:0]  w_mask_o;

    logic                   b_valid_e;
    logic                   b_valid_o;
    logic [`AQ_ADDR_W-1:0]  b_addr_e;
    logic [`AQ_ADDR_W-1:0]  b_addr_o;
    logic [`AQ_DATA_W-1:0]  b_data_e;
    logic [`AQ_DATA_W-1:0]  b_data_o;
    logic                   b_pcd;

    // the write-back entry carries the short fields in its low bits
    always_comb begin
        case (src_i)
            SRC_SW:  core_sel = sw_entry_i;
            SRC_WB:  core_sel = wb_entry_i[`AQ_SHORT_W-1:0];
            default: core_sel = rd_entry_i;
        endcase
    end

    assign {c_valid_e, c_valid_o, c_addr_e, c_addr_o,
            c_size_e, c_size_o, c_ptcid, c_pcd} = core_sel;

    assign {w_data_e, w_data_o, w_mask_e, w_mask_o} = wb_entry_i[`AQ_LONG_W-1:`AQ_SHORT_W];

    assign {b_valid_e, b_valid_o, b_addr_e, b_addr_o,
            b_data_e, b_data_o, b_pcd} = bus_entry_i;

    always_comb begin
        if (src_i == SRC_BUS) begin
            valid_e_o = b_valid_e;
            valid_o_o = b_valid_o;
            addr_e_o  = b_addr_e;
            addr_o_o  = b_addr_o;
            data_e_o  = b_data_e;
            data_o_o  = b_data_o;
            // a line fill writes every byte
            mask_e_o  = '1;
            mask_o_o  = '1;
            size_e_o  = '0;
            size_o_o  = '0;
            ptcid_o   = '0;
            pcd_o     = b_pcd;
        end else begin
            valid_e_o = c_valid_e;
            valid_o_o = c_valid_o;
            addr_e_o  = c_addr_e;
            addr_o_o  = c_addr_o;
            size_e_o  = c_size_e;
            size_o_o  = c_size_o;
            ptcid_o   = c_ptcid;
            pcd_o     = c_pcd;
            data_e_o  = (src_i == SRC_WB) ? w_data_e : '0;
            data_o_o  = (src_i == SRC_WB) ? w_data_o : '0;
            mask_e_o  = (src_i == SRC_WB) ? w_mask_e : '0;
            mask_o_o  = (src_i == SRC_WB) ? w_mask_o : '0;
        end
        // nothing presented
        if (!any_i) begin
            valid_e_o = 1'b0;
            valid_o_o = 1'b0;
        end
    end

endmodule

/* aq_pkg.sv */
package aq_pkg;

    // source currently presented at the output
    typedef enum logic [1:0] {
        SRC_RD  = 2'd0,
        SRC_SW  = 2'd1,
        SRC_WB  = 2'd2,
        SRC_BUS = 2'd3
    } aq_src_e;

endpackage

/* bus_fill_reg.sv */
`include "aq_cfg.svh"

module bus_fill_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  load_i,
    input  logic                  pop_i,
    input  logic                  valid_e_i,
    input  logic                  valid_o_i,
    input  logic [`AQ_ADDR_W-1:0] addr_e_i,
    input  logic [`AQ_ADDR_W-1:0] addr_o_i,
    input  logic [`AQ_DATA_W-1:0] data_e_i,
    input  logic [`AQ_DATA_W-1:0] data_o_i,
    input  logic                  pcd_i,
    output logic [`AQ_FILL_W-1:0] entry_o,
    output logic                  full_o
);

    logic [`AQ_FILL_W-1:0] fill_q;
    logic                  take;
    logic                  retire;

    // a fill being retired makes room for the next one
    assign retire = pop_i && full_o;
    assign take   = load_i && (!full_o || retire);

    always_ff @(posedge clk) begin
        if (take) begin
            fill_q <= {valid_e_i, valid_o_i, addr_e_i, addr_o_i, data_e_i, data_o_i, pcd_i};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_o <= 1'b0;
        end else if (take) begin
            full_o <= 1'b1;
        end else if (retire) begin
            full_o <= 1'b0;
        end
    end

    assign entry_o = full_o ? fill_q : '0;

endmodule

/* cache_aq_sys.f */
+incdir+.
aq_pkg.sv
access_queue.sv
bus_fill_reg.sv
aq_arbiter.sv
aq_out_mux.sv
cache_aq_sys.sv
tb_cache_aq_sys.sv

/* cache_aq_sys.sv */
`include "aq_cfg.svh"

module cache_aq_sys (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // read lookups
    input  logic                   rd_write_i,
    input  logic                   rd_valid_e_i,
    input  logic                   rd_valid_o_i,
    input  logic [`AQ_ADDR_W-1:0]  rd_addr_e_i,
    input  logic [`AQ_ADDR_W-1:0]  rd_addr_o_i,
    input  logic [`AQ_SIZE_W-1:0]  rd_size_e_i,
    input  logic [`AQ_SIZE_W-1:0]  rd_size_o_i,
    input  logic [`AQ_PTCID_W-1:0] rd_ptcid_i,
    input  logic                   rd_pcd_i,
    // store-write checks
    input  logic                   sw_write_i,
    input  logic                   sw_valid_e_i,
    input  logic                   sw_valid_o_i,
    input  logic [`AQ_ADDR_W-1:0]  sw_addr_e_i,
    input  logic [`AQ_ADDR_W-1:0]  sw_addr_o_i,
    input  logic [`AQ_SIZE_W-1:0]  sw_size_e_i,
    input  logic [`AQ_SIZE_W-1:0]  sw_size_o_i,
    input  logic [`AQ_PTCID_W-1:0] sw_ptcid_i,
    input  logic                   sw_pcd_i,
    // write-backs
    input  logic                   wb_write_i,
    input  logic                   wb_valid_e_i,
    input  logic                   wb_valid_o_i,
    input  logic [`AQ_ADDR_W-1:0]  wb_addr_e_i,
    input  logic [`AQ_ADDR_W-1:0]  wb_addr_o_i,
    input  logic [`AQ_SIZE_W-1:0]  wb_size_e_i,
    input  logic [`AQ_SIZE_W-1:0]  wb_size_o_i,
    input  logic [`AQ_PTCID_W-1:0] wb_ptcid_i,
    input  logic                   wb_pcd_i,
    input  logic [`AQ_DATA_W-1:0]  wb_data_e_i,
    input  logic [`AQ_DATA_W-1:0]  wb_data_o_i,
    input  logic [`AQ_MASK_W-1:0]  wb_mask_e_i,
    input  logic [`AQ_MASK_W-1:0]  wb_mask_o_i,
    // bus line fill
    input  logic                   bus_load_i,
    input  logic                   bus_valid_e_i,
    input  logic                   bus_valid_o_i,
    input  logic [`AQ_ADDR_W-1:0]  bus_addr_e_i,
    input  logic [`AQ_ADDR_W-1:0]  bus_addr_o_i,
    input  logic [`AQ_DATA_W-1:0]  bus_data_e_i,
    input  logic [`AQ_DATA_W-1:0]  bus_data_o_i,
    input  logic                   bus_pcd_i,
    input  logic                   read_i,
    // presented request
    output logic                   valid_e_o,
    output logic                   valid_o_o,
    output logic [`AQ_ADDR_W-1:0]  addr_e_o,
    output logic [`AQ_ADDR_W-1:0]  addr_o_o,
    output logic [`AQ_DATA_W-1:0]  data_e_o,
    output logic [`AQ_DATA_W-1:0]  data_o_o,
    output logic [`AQ_SIZE_W-1:0]  size_e_o,
    output logic [`AQ_SIZE_W-1:0]  size_o_o,
    output logic [`AQ_MASK_W-1:0]  mask_e_o,
    output logic [`AQ_MASK_W-1:0]  mask_o_o,
    output logic [`AQ_PTCID_W-1:0] ptcid_o,
    output logic                   pcd_o,
    output logic                   r_o,
    output logic                   sw_o,
    output logic                   w_o,
    output logic                   from_bus_o,
    output logic                   aq_empty_o,
    output logic                   rdaq_full_o,
    output logic                   swaq_full_o,
    output logic                   wbaq_full_o,
    output logic                   bus_full_o
);

    import aq_pkg::*;

    logic [`AQ_SHORT_W-1:0] rd_in;
    logic [`AQ_SHORT_W-1:0] sw_in;
    logic [`AQ_LONG_W-1:0]  wb_in;
    logic [`AQ_SHORT_W-1:0] rd_head;
    logic [`AQ_SHORT_W-1:0] sw_head;
    logic [`AQ_LONG_W-1:0]  wb_head;
    logic [`AQ_FILL_W-1:0]  bus_head;
    logic                   rd_empty;
    logic                   sw_empty;
    logic                   wb_empty;
    logic                   pop_rd;
    logic                   pop_sw;
    logic                   pop_wb;
    logic                   pop_bus;
    aq_src_e                src;

    // entry packing shared with aq_out_mux
    assign rd_in = {rd_valid_e_i, rd_valid_o_i, rd_addr_e_i, rd_addr_o_i,
                    rd_size_e_i, rd_size_o_i, rd_ptcid_i, rd_pcd_i};
    assign sw_in = {sw_valid_e_i, sw_valid_o_i, sw_addr_e_i, sw_addr_o_i,
                    sw_size_e_i, sw_size_o_i, sw_ptcid_i, sw_pcd_i};
    assign wb_in = {wb_data_e_i, wb_data_o_i, wb_mask_e_i, wb_mask_o_i,
                    wb_valid_e_i, wb_valid_o_i, wb_addr_e_i, wb_addr_o_i,
                    wb_size_e_i, wb_size_o_i, wb_ptcid_i, wb_pcd_i};

    access_queue #(.ENTRY_W(`AQ_SHORT_W)) rd_q (
        .clk(clk), .rst_n_i(rst_n_i), .write_i(rd_write_i), .pop_i(pop_rd),
        .entry_i(rd_in), .entry_o(rd_head), .empty_o(rd_empty), .full_o(rdaq_full_o)
    );

    access_queue #(.ENTRY_W(`AQ_SHORT_W)) sw_q (
        .clk(clk), .rst_n_i(rst_n_i), .write_i(sw_write_i), .pop_i(pop_sw),
        .entry_i(sw_in), .entry_o(sw_head), .empty_o(sw_empty), .full_o(swaq_full_o)
    );

    access_queue #(.ENTRY_W(`AQ_LONG_W)) wb_q (
        .clk(clk), .rst_n_i(rst_n_i), .write_i(wb_write_i), .pop_i(pop_wb),
        .entry_i(wb_in), .entry_o(wb_head), .empty_o(wb_empty), .full_o(wbaq_full_o)
    );

    bus_fill_reg i_bus_fill_reg (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(bus_load_i), .pop_i(pop_bus),
        .valid_e_i(bus_valid_e_i), .valid_o_i(bus_valid_o_i),
        .addr_e_i(bus_addr_e_i), .addr_o_i(bus_addr_o_i),
        .data_e_i(bus_data_e_i), .data_o_i(bus_data_o_i), .pcd_i(bus_pcd_i),
        .entry_o(bus_head), .full_o(bus_full_o)
    );

    aq_arbiter i_aq_arbiter (
        .bus_full_i(bus_full_o), .wb_empty_i(wb_empty), .sw_empty_i(sw_empty),
        .rd_empty_i(rd_empty), .read_i(read_i), .src_o(src),
        .r_o(r_o), .sw_o(sw_o), .w_o(w_o), .from_bus_o(from_bus_o),
        .pop_rd_o(pop_rd), .pop_sw_o(pop_sw), .pop_wb_o(pop_wb), .pop_bus_o(pop_bus),
        .aq_empty_o(aq_empty_o)
    );

    aq_out_mux i_aq_out_mux (
        .src_i(src), .any_i(!aq_empty_o),
        .rd_entry_i(rd_head), .sw_entry_i(sw_head),
        .wb_entry_i(wb_head), .bus_entry_i(bus_head),
        .valid_e_o(valid_e_o), .valid_o_o(valid_o_o),
        .addr_e_o(addr_e_o), .addr_o_o(addr_o_o),
        .data_e_o(data_e_o), .data_o_o(data_o_o),
        .size_e_o(size_e_o), .size_o_o(size_o_o),
        .mask_e_o(mask_e_o), .mask_o_o(mask_o_o),
        .ptcid_o(ptcid_o), .pcd_o(pcd_o)
    );

endmodule

/* tb_cache_aq_sys.sv */
`include "aq_cfg.svh"

module tb_cache_aq_sys;

    timeunit 1ns;
    timeprecision 100ps;

    import aq_pkg::*;

    typedef struct packed {
        logic                   valid_e;
        logic                   valid_o;
        logic [`AQ_ADDR_W-1:0]  addr_e;
        logic [`AQ_ADDR_W-1:0]  addr_o;
        logic [`AQ_SIZE_W-1:0]  size_e;
        logic [`AQ_SIZE_W-1:0]  size_o;
        logic [`AQ_PTCID_W-1:0] ptcid;
        logic                   pcd;
        logic [`AQ_DATA_W-1:0]  data_e;
        logic [`AQ_DATA_W-1:0]  data_o;
        logic [`AQ_MASK_W-1:0]  mask_e;
        logic [`AQ_MASK_W-1:0]  mask_o;
    } req_t;

    logic clk, rst_n_i, read_i;
    logic rd_write_i, sw_write_i, wb_write_i, bus_load_i;
    logic valid_e_o, valid_o_o, pcd_o;
    logic r_o, sw_o, w_o, from_bus_o, aq_empty_o;
    logic rdaq_full_o, swaq_full_o, wbaq_full_o, bus_full_o;
    logic [`AQ_ADDR_W-1:0]  addr_e_o, addr_o_o;
    logic [`AQ_DATA_W-1:0]  data_e_o, data_o_o;
    logic [`AQ_SIZE_W-1:0]  size_e_o, size_o_o;
    logic [`AQ_MASK_W-1:0]  mask_e_o, mask_o_o;
    logic [`AQ_PTCID_W-1:0] ptcid_o;

    req_t   drv;
    integer seed = 3712;
    int     errors = 0;
    int     tests = 0;
    int     failed_tests = 0;

    // one set of field values feeds every stream and the strobes pick the target
    cache_aq_sys i_cache_aq_sys (
        .rd_valid_e_i(drv.valid_e), .rd_valid_o_i(drv.valid_o),
        .rd_addr_e_i(drv.addr_e), .rd_addr_o_i(drv.addr_o),
        .rd_size_e_i(drv.size_e), .rd_size_o_i(drv.size_o),
        .rd_ptcid_i(drv.ptcid), .rd_pcd_i(drv.pcd),
        .sw_valid_e_i(drv.valid_e), .sw_valid_o_i(drv.valid_o),
        .sw_addr_e_i(drv.addr_e), .sw_addr_o_i(drv.addr_o),
        .sw_size_e_i(drv.size_e), .sw_size_o_i(drv.size_o),
        .sw_ptcid_i(drv.ptcid), .sw_pcd_i(drv.pcd),
        .wb_valid_e_i(drv.valid_e), .wb_valid_o_i(drv.valid_o),
        .wb_addr_e_i(drv.addr_e), .wb_addr_o_i(drv.addr_o),
        .wb_size_e_i(drv.size_e), .wb_size_o_i(drv.size_o),
        .wb_ptcid_i(drv.ptcid), .wb_pcd_i(drv.pcd),
        .wb_data_e_i(drv.data_e), .wb_data_o_i(drv.data_o),
        .wb_mask_e_i(drv.mask_e), .wb_mask_o_i(drv.mask_o),
        .bus_valid_e_i(drv.valid_e), .bus_valid_o_i(drv.valid_o),
        .bus_addr_e_i(drv.addr_e), .bus_addr_o_i(drv.addr_o),
        .bus_data_e_i(drv.data_e), .bus_data_o_i(drv.data_o), .bus_pcd_i(drv.pcd),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic req_t rand_req();
        logic [127:0] raw;
        req_t         r;
        raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
        r = raw[$bits(req_t)-1:0];
        r.valid_e = 1'b1;
        return r;
    endfunction

    // what the output should show for a request from a given source
    function automatic req_t shown_as(input aq_src_e s, input req_t r);
        req_t e;
        e = r;
        if (s == SRC_RD || s == SRC_SW) begin
            e.data_e = '0;
            e.data_o = '0;
            e.mask_e = '0;
            e.mask_o = '0;
        end else if (s == SRC_BUS) begin
            e.size_e = '0;
            e.size_o = '0;
            e.ptcid  = '0;
            e.mask_e = '1;
            e.mask_o = '1;
        end
        return e;
    endfunction

    task automatic push(input aq_src_e s, input req_t r, input logic with_pop);
        drv        = r;
        rd_write_i = (s == SRC_RD);
        sw_write_i = (s == SRC_SW);
        wb_write_i = (s == SRC_WB);
        bus_load_i = (s == SRC_BUS);
        read_i     = with_pop;
        step();
        rd_write_i = 1'b0;
        sw_write_i = 1'b0;
        wb_write_i = 1'b0;
        bus_load_i = 1'b0;
        read_i     = 1'b0;
    endtask

    task automatic pop_one();
        read_i = 1'b1;
        step();
        read_i = 1'b0;
    endtask

    task automatic wait_present(input string what);
        int n;
        n = 0;
        while (aq_empty_o && n < 10) begin
            step();
            n++;
        end
        if (aq_empty_o) begin
            $display("timeout: no request presented while waiting for %s", what);
            errors++;
        end
    endtask

    task automatic expect_idle();
        check("aq_empty_o", 64'(1), 64'(aq_empty_o));
        check("r_o", 64'(0), 64'(r_o));
        check("sw_o", 64'(0), 64'(sw_o));
        check("w_o", 64'(0), 64'(w_o));
        check("from_bus_o", 64'(0), 64'(from_bus_o));
        check("valid_e_o", 64'(0), 64'(valid_e_o));
        check("valid_o_o", 64'(0), 64'(valid_o_o));
    endtask

    task automatic expect_front(input aq_src_e s, input req_t r);
        req_t e;
        e = shown_as(s, r);
        check("aq_empty_o", 64'(0), 64'(aq_empty_o));
        check("r_o", 64'(s == SRC_RD), 64'(r_o));
        check("sw_o", 64'(s == SRC_SW), 64'(sw_o));
        check("w_o", 64'(s == SRC_WB), 64'(w_o));
        check("from_bus_o", 64'(s == SRC_BUS), 64'(from_bus_o));
        check("valid_e_o", 64'(e.valid_e), 64'(valid_e_o));
        check("valid_o_o", 64'(e.valid_o), 64'(valid_o_o));
        check("addr_e_o", 64'(e.addr_e), 64'(addr_e_o));
        check("addr_o_o", 64'(e.addr_o), 64'(addr_o_o));
        check("size_e_o", 64'(e.size_e), 64'(size_e_o));
        check("size_o_o", 64'(e.size_o), 64'(size_o_o));
        check("ptcid_o", 64'(e.ptcid), 64'(ptcid_o));
        check("pcd_o", 64'(e.pcd), 64'(pcd_o));
        check("data_e_o", 64'(e.data_e), 64'(data_e_o));
        check("data_o_o", 64'(e.data_o), 64'(data_o_o));
        check("mask_e_o", 64'(e.mask_e), 64'(mask_e_o));
        check("mask_o_o", 64'(e.mask_o), 64'(mask_o_o));
    endtask

    task automatic report(input string name, input int errors_before);
        tests++;
        if (errors != errors_before) begin
            failed_tests++;
            $display("test %s: FAIL with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic after_reset();
        int e0;
        e0 = errors;
        expect_idle();
        check("rdaq_full_o", 64'(0), 64'(rdaq_full_o));
        check("swaq_full_o", 64'(0), 64'(swaq_full_o));
        check("wbaq_full_o", 64'(0), 64'(wbaq_full_o));
        check("bus_full_o", 64'(0), 64'(bus_full_o));
        report("reset", e0);
    endtask

    task automatic single_read();
        int   e0;
        req_t r;
        e0 = errors;
        r = rand_req();
        push(SRC_RD, r, 1'b0);
        expect_front(SRC_RD, r);
        pop_one();
        expect_idle();
        report("single_read", e0);
    endtask

    task automatic priority_order();
        int   e0;
        req_t r [4];
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            r[i] = rand_req();
        end
        push(SRC_RD, r[0], 1'b0);
        push(SRC_SW, r[1], 1'b0);
        push(SRC_WB, r[2], 1'b0);
        push(SRC_BUS, r[3], 1'b0);
        wait_present("priority order");
        expect_front(SRC_BUS, r[3]);
        pop_one();
        expect_front(SRC_WB, r[2]);
        pop_one();
        expect_front(SRC_SW, r[1]);
        pop_one();
        expect_front(SRC_RD, r[0]);
        pop_one();
        expect_idle();
        report("priority", e0);
    endtask

    task automatic fifo_overflow();
        int   e0;
        req_t q [5];
        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            q[i] = rand_req();
            push(SRC_RD, q[i], 1'b0);
            check("rdaq_full_o", 64'(i >= `AQ_DEPTH - 1), 64'(rdaq_full_o));
        end
        // the fifth entry never made it in
        for (int i = 0; i < `AQ_DEPTH; i++) begin
            expect_front(SRC_RD, q[i]);
            pop_one();
        end
        expect_idle();
        check("rdaq_full_o", 64'(0), 64'(rdaq_full_o));
        report("overflow", e0);
    endtask

    task automatic wb_full_swap();
        int   e0;
        req_t w [5];
        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            w[i] = rand_req();
        end
        for (int i = 0; i < `AQ_DEPTH; i++) begin
            push(SRC_WB, w[i], 1'b0);
        end
        check("wbaq_full_o", 64'(1), 64'(wbaq_full_o));
        expect_front(SRC_WB, w[0]);
        push(SRC_WB, w[4], 1'b1);
        check("wbaq_full_o", 64'(1), 64'(wbaq_full_o));
        for (int i = 1; i < 5; i++) begin
            expect_front(SRC_WB, w[i]);
            pop_one();
        end
        expect_idle();
        report("wb_full_swap", e0);
    endtask

    task automatic bus_hold();
        int   e0;
        req_t b0;
        req_t b1;
        e0 = errors;
        b0 = rand_req();
        b1 = rand_req();
        push(SRC_BUS, b0, 1'b0);
        wait_present("bus fill");
        expect_front(SRC_BUS, b0);
        push(SRC_BUS, b1, 1'b0);
        check("bus_full_o", 64'(1), 64'(bus_full_o));
        expect_front(SRC_BUS, b0);
        step();
        step();
        expect_front(SRC_BUS, b0);
        pop_one();
        expect_idle();
        check("bus_full_o", 64'(0), 64'(bus_full_o));
        report("bus_hold", e0);
    endtask

    initial begin
        drv        = '0;
        rst_n_i    = 1'b0;
        read_i     = 1'b0;
        rd_write_i = 1'b0;
        sw_write_i = 1'b0;
        wb_write_i = 1'b0;
        bus_load_i = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        step();
        after_reset();
        single_read();
        priority_order();
        fifo_overflow();
        wb_full_swap();
        bus_hold();
        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
